//--- arb_pkg.sv
`default_nettype none

package arb_pkg;

  // default sizes of the arbiter
  parameter int num_in_def     = 4;   // upstream channels
  parameter int data_w_def     = 10;  // word width
  parameter int fifo_depth_def = 2;   // output queue entries, any value >= 1

  // bits needed to index n items, never less than one
  function automatic int idx_w(input int n);
    int w;
    w = (n > 1) ? $clog2(n) : 1;
    return w;
  endfunction

  // bits needed for a count that runs from 0 up to depth inclusive
  function automatic int cnt_w(input int depth);
    int w;
    w = $clog2(depth + 1);
    if (w < 1) begin
      w = 1;
    end
    return w;
  endfunction

endpackage

`default_nettype wire

//--- skid_buf.sv
`default_nettype none
`timescale 1ns/1ns

module skid_buf #(
  parameter int data_w = arb_pkg::data_w_def
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid_us,
  input  logic [data_w-1:0] data_us,
  output logic              stall_us,
  output logic              valid_ds,
  output logic [data_w-1:0] data_ds,
  input  logic              stall_ds
);

  import arb_pkg::*;

  logic              stall_r;     // stall_ds seen last cycle
  logic              held_valid;
  logic              held_valid_n;
  logic [data_w-1:0] held_data;
  logic              load;

  // upstream only sees the stall one cycle late
  assign stall_us = stall_r & valid_us;

  // word slipping through during the first stalled cycle goes into the holding slot
  assign load = ~held_valid & valid_us & ~stall_r & stall_ds;

  always_comb begin
    if (held_valid) begin
      held_valid_n = stall_ds;    // drains once downstream takes it
    end else begin
      held_valid_n = load;
    end
  end

  // held word always goes first
  // live input is hidden while upstream is being stalled
  assign valid_ds = held_valid | (valid_us & ~stall_r);
  assign data_ds  = held_valid ? held_data : data_us;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stall_r    <= 1'b0;
      held_valid <= 1'b0;
    end else begin
      stall_r    <= stall_ds;
      held_valid <= held_valid_n;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      held_data <= data_us;
    end
  end

endmodule

`default_nettype wire

//--- rr_grant.sv
`default_nettype none
`timescale 1ns/1ns

module rr_grant #(
  parameter int num_in = arb_pkg::num_in_def,
  parameter int data_w = arb_pkg::data_w_def
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [num_in-1:0]              cand_valid,
  input  logic [num_in-1:0][data_w-1:0]  cand_data,
  output logic [num_in-1:0]              cand_stall,
  input  logic                           full,
  output logic                           wr_en,
  output logic [data_w-1:0]              wr_data
);

  import arb_pkg::*;

  localparam int ptr_w = idx_w(num_in);

  logic [ptr_w-1:0]  base;        // first input looked at this cycle
  logic [ptr_w-1:0]  base_n;
  logic [num_in-1:0] gnt;         // one-hot, or zero
  logic              found;
  logic [data_w-1:0] sel_data;

  // scan base, base+1, ... and take the first valid candidate
  always_comb begin
    int idx;
    idx      = 0;
    gnt      = '0;
    found    = 1'b0;
    sel_data = '0;
    for (int k = 0; k < num_in; k++) begin
      idx = int'(base) + k;
      if (idx >= num_in) begin
        idx = idx - num_in;       // wrap around the channel count
      end
      if (!found && cand_valid[idx]) begin
        found    = 1'b1;
        sel_data = cand_data[idx];
        if (!full) begin
          gnt[idx] = 1'b1;
        end
      end
    end
  end

  assign wr_en   = found & ~full;   // nothing goes in while the queue is full
  assign wr_data = sel_data;

  // every waiting candidate that lost is held back
  assign cand_stall = cand_valid & ~gnt;

  // base moves by one per grant, not past the winner
  always_comb begin
    base_n = base;
    if (wr_en) begin
      if (base == ptr_w'(num_in - 1)) begin
        base_n = '0;
      end else begin
        base_n = base + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      base <= '0;
    end else begin
      base <= base_n;
    end
  end

endmodule

`default_nettype wire

//--- out_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module out_fifo #(
  parameter int data_w = arb_pkg::data_w_def,
  parameter int depth  = arb_pkg::fifo_depth_def
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_en,
  input  logic [data_w-1:0] wr_data,
  input  logic              rd_en,
  output logic [data_w-1:0] rd_data,
  output logic              full,
  output logic              empty
);

  import arb_pkg::*;

  localparam int ptr_w = idx_w(depth);
  localparam int c_w   = cnt_w(depth);

  logic [data_w-1:0] mem [depth];
  logic [ptr_w-1:0]  rd_ptr;
  logic [ptr_w-1:0]  wr_ptr;
  logic [c_w-1:0]    count;       // entries currently held
  logic [c_w-1:0]    count_n;
  logic              wr_ok;
  logic              rd_ok;

  // step a pointer, wrapping at depth since depth need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    logic [ptr_w-1:0] q;
    if (p == ptr_w'(depth - 1)) begin
      q = '0;
    end else begin
      q = p + 1'b1;
    end
    return q;
  endfunction

  assign full  = (count == c_w'(depth));
  assign empty = (count == '0);

  assign wr_ok = wr_en & ~full;   // write into a full queue is dropped
  assign rd_ok = rd_en & ~empty;  // read of an empty queue does nothing

  assign rd_data = mem[rd_ptr];   // head is always on the output

  always_comb begin
    case ({wr_ok, rd_ok})
      2'b10:   count_n = count + 1'b1;
      2'b01:   count_n = count - 1'b1;
      default: count_n = count;   // both or neither
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_ok) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count_n;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- stall_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module stall_arbiter #(
  parameter int num_in     = arb_pkg::num_in_def,
  parameter int data_w     = arb_pkg::data_w_def,
  parameter int fifo_depth = arb_pkg::fifo_depth_def
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [num_in-1:0]             valid_us,
  input  logic [num_in-1:0][data_w-1:0] data_us,
  output logic [num_in-1:0]             stall_us,
  output logic                          valid_ds,
  output logic [data_w-1:0]             data_ds,
  input  logic                          stall_ds
);

  import arb_pkg::*;

  logic [num_in-1:0]             cand_valid;
  logic [num_in-1:0][data_w-1:0] cand_data;
  logic [num_in-1:0]             cand_stall;
  logic                          wr_en;
  logic [data_w-1:0]             wr_data;
  logic                          rd_en;
  logic [data_w-1:0]             rd_data;
  logic                          full;
  logic                          empty;

  // input stage, one skid per channel
  for (genvar i = 0; i < num_in; i++) begin : g_in
    skid_buf #(
      .data_w (data_w)
    ) u_skid_buf (
      .clk      (clk),
      .rst      (rst),
      .valid_us (valid_us[i]),
      .data_us  (data_us[i]),
      .stall_us (stall_us[i]),
      .valid_ds (cand_valid[i]),
      .data_ds  (cand_data[i]),
      .stall_ds (cand_stall[i])
    );
  end

  // grant stage
  rr_grant #(
    .num_in (num_in),
    .data_w (data_w)
  ) u_rr_grant (
    .clk        (clk),
    .rst        (rst),
    .cand_valid (cand_valid),
    .cand_data  (cand_data),
    .cand_stall (cand_stall),
    .full       (full),
    .wr_en      (wr_en),
    .wr_data    (wr_data)
  );

  // output queue
  out_fifo #(
    .data_w (data_w),
    .depth  (fifo_depth)
  ) u_out_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .full    (full),
    .empty   (empty)
  );

  assign valid_ds = ~empty;
  assign data_ds  = rd_data;
  assign rd_en    = valid_ds & ~stall_ds;  // pop on each delivered word

endmodule

`default_nettype wire

//--- tb_stall_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module tb_stall_arbiter;

  import arb_pkg::*;

  localparam int num_in      = num_in_def;
  localparam int data_w      = data_w_def;
  localparam int fifo_depth  = fifo_depth_def;
  localparam int tag_w       = idx_w(num_in);
  localparam int seq_w       = data_w - tag_w;
  localparam int mq_size     = 16;        // far more entries per channel than can be in flight
  localparam int half_period = 5;

  // source behaviors
  localparam int src_idle   = 0;
  localparam int src_random = 1;
  localparam int src_busy   = 2;          // valid every cycle
  localparam int src_drain  = 3;          // finish the current word and then stop

  // downstream stall behaviors
  localparam int stall_low    = 0;
  localparam int stall_random = 1;
  localparam int stall_high   = 2;

  logic                          clk;
  logic                          rst;
  logic [num_in-1:0]             valid_us;
  logic [num_in-1:0][data_w-1:0] data_us;
  logic [num_in-1:0]             stall_us;
  logic                          valid_ds;
  logic [data_w-1:0]             data_ds;
  logic                          stall_ds;

  logic [31:0]       lfsr;
  int                src_mode;
  int                stall_mode;
  logic [seq_w-1:0]  seq [num_in];        // next sequence number per channel
  logic [num_in-1:0] accepted;            // handshake done at the last edge

  // scoreboard
  logic [data_w-1:0] mq [num_in][mq_size];
  int                mq_head [num_in];
  int                mq_cnt [num_in];
  int                outstanding;         // accepted minus delivered
  int                delivered;

  logic              check_order;
  logic              have_last;
  int                last_ch;
  logic              held_prev;           // last cycle ended stalled with a valid word
  logic [data_w-1:0] held_data_prev;

  int value_errors;
  int order_errors;
  int protocol_errors;

  stall_arbiter #(
    .num_in     (num_in),
    .data_w     (data_w),
    .fifo_depth (fifo_depth)
  ) u_stall_arbiter (
    .clk      (clk),
    .rst      (rst),
    .valid_us (valid_us),
    .data_us  (data_us),
    .stall_us (stall_us),
    .valid_ds (valid_ds),
    .data_ds  (data_ds),
    .stall_ds (stall_ds)
  );

  always #half_period clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);           // one step per bit taken
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic queues_empty();
    logic e;
    e = 1'b1;
    for (int i = 0; i < num_in; i++) begin
      if (mq_cnt[i] != 0) begin
        e = 1'b0;
      end
    end
    return e;
  endfunction

  task automatic check_idle_outputs();
    if (valid_ds !== 1'b0 || stall_us !== '0) begin
      value_errors++;
      $display("Fail at %0t: valid_ds=%b stall_us=%b, expected all low around reset",
               $time, valid_ds, stall_us);
    end
  endtask

  // called on the falling edge
  task automatic drive_inputs();
    logic [31:0] r;
    for (int i = 0; i < num_in; i++) begin
      if (!(valid_us[i] && !accepted[i])) begin  // a stalled word stays as it is
        if (accepted[i]) begin
          seq[i] = seq[i] + 1'b1;
        end
        case (src_mode)
          src_random: begin
            r = rand_bits(1);
            valid_us[i] = r[0];
          end
          src_busy: valid_us[i] = 1'b1;
          default:  valid_us[i] = 1'b0;
        endcase
        data_us[i] = {tag_w'(i), seq[i]};     // channel in the top bits
      end
    end
    case (stall_mode)
      stall_random: begin
        r = rand_bits(1);
        stall_ds = r[0];
      end
      stall_high: stall_ds = 1'b1;
      default:    stall_ds = 1'b0;
    endcase
  endtask

  // called just before the rising edge once everything has settled
  task automatic sample_outputs();
    int ch;
    int slot;
    logic [data_w-1:0] exp;
    if (held_prev) begin
      if (!valid_ds) begin
        protocol_errors++;
        $display("Fail at %0t: valid_ds dropped while the word was stalled", $time);
      end else if (data_ds !== held_data_prev) begin
        value_errors++;
        $display("Fail at %0t: stalled word changed from %h to %h",
                 $time, held_data_prev, data_ds);
      end
    end
    held_prev      = valid_ds & stall_ds;
    held_data_prev = data_ds;

    // a word only leaves after the edge that took it in
    if (valid_ds && !stall_ds) begin
      ch = int'(data_ds[data_w-1 -: tag_w]);
      delivered++;
      if (mq_cnt[ch] == 0) begin
        protocol_errors++;
        $display("Fail at %0t: channel %0d delivered word %h with nothing outstanding",
                 $time, ch, data_ds);
      end else begin
        exp = mq[ch][mq_head[ch]];
        if (data_ds !== exp) begin
          value_errors++;
          $display("Fail at %0t: channel %0d delivered %h, expected %h",
                   $time, ch, data_ds, exp);
        end
        mq_head[ch] = (mq_head[ch] + 1) % mq_size;
        mq_cnt[ch]--;
        outstanding--;
      end
      if (check_order && have_last && ch != (last_ch + 1) % num_in) begin
        order_errors++;
        $display("Fail at %0t: channel %0d followed channel %0d", $time, ch, last_ch);
      end
      last_ch   = ch;
      have_last = 1'b1;
    end

    for (int i = 0; i < num_in; i++) begin
      accepted[i] = valid_us[i] & ~stall_us[i];
      if (accepted[i]) begin
        if (mq_cnt[i] == mq_size) begin
          protocol_errors++;
          $display("model queue of channel %0d overflowed at %0t", i, $time);
        end else begin
          slot = (mq_head[i] + mq_cnt[i]) % mq_size;
          mq[i][slot] = data_us[i];
          mq_cnt[i]++;
          outstanding++;
        end
      end
    end

    if (outstanding > fifo_depth + num_in) begin
      protocol_errors++;
      $display("%0d words in flight at %0t, more than the DUT can hold", outstanding, $time);
    end
  endtask

  task automatic step();
    @(negedge clk);
    drive_inputs();
    #(half_period - 1);
    sample_outputs();
  endtask

  initial begin
    int   waited;
    logic done;
    clk             = 1'b0;
    rst             = 1'b1;
    valid_us        = '0;
    data_us         = '0;
    stall_ds        = 1'b0;
    lfsr            = 32'd73170;
    src_mode        = src_idle;
    stall_mode      = stall_low;
    accepted        = '0;
    outstanding     = 0;
    delivered       = 0;
    check_order     = 1'b0;
    have_last       = 1'b0;
    last_ch         = 0;
    held_prev       = 1'b0;
    held_data_prev  = '0;
    value_errors    = 0;
    order_errors    = 0;
    protocol_errors = 0;
    for (int i = 0; i < num_in; i++) begin
      seq[i]     = '0;
      mq_head[i] = 0;
      mq_cnt[i]  = 0;
    end

    repeat (16) begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst = 1'b0;
    #(half_period - 1);
    check_idle_outputs();
    sample_outputs();
    step();                             // first edge out of reset with idle inputs
    check_idle_outputs();

    // random traffic both sides
    src_mode   = src_random;
    stall_mode = stall_random;
    repeat (300) step();

    // saturated inputs with a free output rotate strictly
    src_mode   = src_busy;
    stall_mode = stall_low;
    repeat (8) step();                  // let older queue entries flush
    check_order = 1'b1;
    have_last   = 1'b0;
    delivered   = 0;
    repeat (100) step();
    check_order = 1'b0;
    if (delivered < 90) begin
      protocol_errors++;
      $display("only %0d words delivered in the saturated phase", delivered);
    end

    // saturated inputs against a random stall
    stall_mode = stall_random;
    repeat (150) step();

    // every input should end up stalled under a long stall
    stall_mode = stall_high;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 40) begin
      step();
      waited++;
      if (&valid_us && &stall_us) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      protocol_errors++;
      $display("timeout: inputs were not all stalled under a held stall_ds");
    end
    repeat (30) step();

    // stop the sources and release the output
    src_mode   = src_drain;
    stall_mode = stall_low;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 200) begin
      step();
      waited++;
      if (queues_empty() && valid_us == '0 && !valid_ds) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      protocol_errors++;
      $display("timeout: %0d accepted words never came out", outstanding);
    end

    $display("errors: %0d value, %0d order, %0d protocol",
             value_errors, order_errors, protocol_errors);
    if (value_errors + order_errors + protocol_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
arb_pkg.sv
skid_buf.sv
rr_grant.sv
out_fifo.sv
stall_arbiter.sv
tb_stall_arbiter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the arbiter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module tb_stall_arbiter \
  -f vlog.f

./obj_dir/Vtb_stall_arbiter | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0
